// File: rtl/bch_pkg.sv
package bch_pkg;

	// ********************
	// field and code
	// ********************

	localparam int M = 4;                                // bits per field element.
	localparam int N = (1 << M) - 1;                     // code length.

	localparam logic [M:0] PRIM_POLY = 5'b10011;          // x^4 + x + 1.

	// ********************
	// constant helpers
	// ********************

	// alpha^k, exponent taken modulo N so negative powers work too.
	function automatic logic [M-1:0] gf_pow(input int k);
		int e;
		logic [M-1:0] r;
		e = k % N;
		if (e < 0)
			e = e + N;                                    // fold negative exponents.
		r = {{(M-1){1'b0}}, 1'b1};                        // alpha^0.
		for (int i = 0; i < e; i++) begin
			if (r[M-1])
				r = {r[M-2:0], 1'b0} ^ PRIM_POLY[M-1:0];   // multiply by x and reduce.
			else
				r = {r[M-2:0], 1'b0};
		end
		return r;
	endfunction

	// number of beats in one codeword.
	function automatic int beats_per_word(input int bits);
		return N / bits;
	endfunction

endpackage

// File: rtl/gf_mult.sv
module gf_mult
	import bch_pkg::*;
(
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] p
);

	localparam int PW = 2 * M - 1;                    // width of the raw product.

	logic [PW-1:0] prod_raw;                          // carry-less product.
	logic [PW-1:0] prod_red;                          // after reduction.

	// ********************
	// shift and add
	// ********************

	always_comb begin
		prod_raw = '0;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				prod_raw = prod_raw ^ ({{(M-1){1'b0}}, a} << i);
		end
	end

	// ********************
	// reduction
	// ********************

	always_comb begin
		prod_red = prod_raw;
		for (int k = PW - 1; k >= M; k--) begin
			if (prod_red[k])
				prod_red = prod_red ^ ({{(M-2){1'b0}}, PRIM_POLY} << (k - M));
		end
	end

	assign p = prod_red[M-1:0];                       // only low M bits remain.

endmodule

// File: rtl/syn_unit.sv
module syn_unit
	import bch_pkg::*;
#(
	parameter int BITS = 3,
	parameter int J = 1
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            beat_en,
	input  logic            first_beat,
	input  logic [BITS-1:0] in_data,
	output logic [M-1:0]    syn_j
);

	// power for bit 0 of beat 0, the x^(N-1) coefficient.
	localparam logic [M-1:0] POW_INIT = gf_pow(J * (N - 1));
	// steps the power register down by one beat.
	localparam logic [M-1:0] POW_STEP = gf_pow(-(J * BITS));

	logic [M-1:0]      pow;                           // power for bit 0 of this beat.
	logic [M-1:0]      pow_curr;                      // with start value muxed in.
	logic [M-1:0]      pow_next;
	logic [BITS*M-1:0] pow_all;                       // one power per bit position.
	logic [M-1:0]      terms_sum;

	// no set/reset path for the start value, so it is a mux.
	assign pow_curr = first_beat ? POW_INIT : pow;

	// ********************
	// per-bit powers
	// ********************

	for (genvar i = 0; i < BITS; i++) begin : gen_bit
		localparam logic [M-1:0] BIT_POW = gf_pow(-(J * i));

		gf_mult u_bit_mult (
			.a (pow_curr),
			.b (BIT_POW),
			.p (pow_all[i*M +: M])
		);
	end

	gf_mult u_step_mult (
		.a (pow_curr),
		.b (POW_STEP),
		.p (pow_next)
	);

	// set bits add their power.
	always_comb begin
		terms_sum = '0;
		for (int i = 0; i < BITS; i++) begin
			if (in_data[i])
				terms_sum = terms_sum ^ pow_all[i*M +: M];
		end
	end

	// ********************
	// accumulator
	// ********************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pow   <= POW_INIT;
			syn_j <= '0;
		end else if (beat_en) begin
			pow <= pow_next;                          // move to next beat.
			if (first_beat)
				syn_j <= terms_sum;                   // fresh word.
			else
				syn_j <= syn_j ^ terms_sum;
		end
	end

endmodule

// File: rtl/syn_expand.sv
module syn_expand
	import bch_pkg::*;
#(
	parameter int T = 2
) (
	input  logic [T*M-1:0]   syn_odd,
	output logic [2*T*M-1:0] syn,
	output logic             syn_error
);

	logic [2*T*M-1:0] syn_all;                        // S1 in the low bits.

	// ********************
	// odd pass, even square
	// ********************

	for (genvar j = 1; j <= 2 * T; j++) begin : gen_syn
		if (j % 2 == 1) begin : gen_odd
			assign syn_all[(j-1)*M +: M] = syn_odd[((j-1)/2)*M +: M];
		end else begin : gen_even
			// S_2k = S_k squared in characteristic 2.
			gf_mult u_square (
				.a (syn_all[(j/2-1)*M +: M]),
				.b (syn_all[(j/2-1)*M +: M]),
				.p (syn_all[(j-1)*M +: M])
			);
		end
	end

	assign syn       = syn_all;
	assign syn_error = |syn_all;                      // any nonzero syndrome.

endmodule

// File: rtl/syn_ctrl.sv
module syn_ctrl
	import bch_pkg::*;
#(
	parameter int BITS = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	output logic beat_en,
	output logic first_beat,
	output logic syn_valid,
	input  logic syn_ready
);

	localparam int BEATS = beats_per_word(BITS);
	localparam int CW    = (BEATS > 1) ? $clog2(BEATS) : 1;

	localparam logic [CW-1:0] LAST_CNT = CW'(BEATS - 1);

	logic [CW-1:0] beat_cnt;                          // beat index inside the word.
	logic          last_beat;

	// ********************
	// handshake
	// ********************

	assign in_ready   = ~syn_valid;                   // a held result stalls input.
	assign beat_en    = in_valid & in_ready;
	assign first_beat = (beat_cnt == '0);
	assign last_beat  = (beat_cnt == LAST_CNT);

	// ********************
	// beat counter
	// ********************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (beat_en) begin
			if (last_beat)
				beat_cnt <= '0;                       // wrap at word end.
			else
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// ********************
	// result valid
	// ********************

	// set on the last beat, cleared when the result is taken.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn_valid <= 1'b0;
		end else if (beat_en && last_beat) begin
			syn_valid <= 1'b1;
		end else if (syn_ready) begin
			syn_valid <= 1'b0;
		end
	end

endmodule

// File: rtl/bch_syndrome.sv
module bch_syndrome
	import bch_pkg::*;
#(
	parameter int BITS = 3,
	parameter int T = 2
) (
	input  logic             clk,
	input  logic             rst_n,

	// received bits, highest degree first.
	input  logic             in_valid,
	output logic             in_ready,
	input  logic [BITS-1:0]  in_data,

	// syndromes S1 .. S2T.
	output logic             syn_valid,
	input  logic             syn_ready,
	output logic [2*T*M-1:0] syn,
	output logic             syn_error
);

	logic           beat_en;
	logic           first_beat;
	logic [T*M-1:0] syn_odd;                          // S1, S3, ... packed low first.

	// ********************
	// control
	// ********************

	syn_ctrl #(
		.BITS (BITS)
	) u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.beat_en    (beat_en),
		.first_beat (first_beat),
		.syn_valid  (syn_valid),
		.syn_ready  (syn_ready)
	);

	// ********************
	// odd syndromes
	// ********************

	for (genvar t = 0; t < T; t++) begin : gen_unit
		syn_unit #(
			.BITS (BITS),
			.J    (2 * t + 1)
		) u_unit (
			.clk        (clk),
			.rst_n      (rst_n),
			.beat_en    (beat_en),
			.first_beat (first_beat),
			.in_data    (in_data),
			.syn_j      (syn_odd[t*M +: M])
		);
	end

	// even syndromes and error flag.
	syn_expand #(
		.T (T)
	) u_expand (
		.syn_odd   (syn_odd),
		.syn       (syn),
		.syn_error (syn_error)
	);

endmodule

// File: sim/bch_syndrome_properties.sv
module bch_syndrome_properties (
	input logic clk,
	input logic rst_n,
	input logic in_ready,
	input logic beat_en,
	input logic syn_valid,
	input logic syn_ready
);

	// ********************
	// reset
	// ********************

	a_valid_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !syn_valid)
		else $error("syn_valid high right out of reset");

	// ********************
	// handshake
	// ********************

	// a held result stalls the input.
	a_ready_blocked: assert property (@(posedge clk) disable iff (!rst_n)
		syn_valid |-> !in_ready)
		else $error("in_ready high while a result is held");

	a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		syn_valid && !syn_ready |=> syn_valid)
		else $error("syn_valid dropped before the result was taken");

	// a result shows up one cycle after the beat that completes the word.
	a_valid_after_beat: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(syn_valid) |-> $past(beat_en))
		else $error("syn_valid rose without a beat the cycle before");

endmodule

// File: sim/bch_syndrome_tb.sv
module bch_syndrome_tb
	import bch_pkg::*;
();

	localparam int          BITS         = 3;
	localparam int          T            = 2;
	localparam int          SYN_W        = 2 * T * M;
	localparam int          BEATS        = N / BITS;
	localparam int          NUM_VEC      = 19;              // lines of data in the stim file.
	localparam int          NUM_PASS     = 2;               // gapless pass, then gapped pass.
	localparam int          CLK_PER      = 8;
	localparam int          DRIVE_DLY    = 1;
	localparam int          RST_CYC      = 10;
	localparam int          WATCHDOG_CYC = NUM_VEC * NUM_PASS * (BEATS + 1) * 20;
	localparam logic [31:0] SEED         = 32'hc3147493;
	localparam string       STIM_FILE    = "sim/syn_stim.txt";

	logic             clk;
	logic             rst_n;
	logic             in_valid;
	logic             in_ready;
	logic [BITS-1:0]  in_data;
	logic             syn_valid;
	logic             syn_ready;
	logic [SYN_W-1:0] syn;
	logic             syn_error;

	logic [15:0]      stim_mem [0:2*NUM_VEC-1];         // codeword, then expected syndromes.
	logic [M-1:0]     gf_exp [0:N-1];                   // alpha^k.
	int               gf_log [0:N];                     // log of a nonzero element.
	integer           seed_feed;
	integer           seed_rcv;
	int               rcv_cnt;

	always #(CLK_PER / 2) clk = ~clk;

	bind syn_ctrl bch_syndrome_properties u_props (.*);

	bch_syndrome #(
		.BITS (BITS),
		.T    (T)
	) UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.syn_valid (syn_valid),
		.syn_ready (syn_ready),
		.syn       (syn),
		.syn_error (syn_error)
	);

	// ********************
	// helpers
	// ********************

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;                                     // drive just after the edge.
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("test failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// x^4 = x + 1 gives the next power.
	task automatic build_gf_tables();
		logic [M-1:0] r;
		r = 4'b0001;
		for (int k = 0; k < N; k++) begin
			gf_exp[k] = r;
			gf_log[r] = k;
			r = r[M-1] ? ({r[M-2:0], 1'b0} ^ 4'b0011) : {r[M-2:0], 1'b0};
		end
	endtask

	function automatic logic [M-1:0] gf_square(input logic [M-1:0] v);
		if (v == '0)
			return '0;
		return gf_exp[(2 * gf_log[v]) % N];
	endfunction

	// bit i of beat b carries x^(N-1-(b*BITS+i)).
	function automatic logic [BITS-1:0] beat_bits(input logic [15:0] cw, input int b);
		logic [BITS-1:0] d;
		for (int i = 0; i < BITS; i++)
			d[i] = cw[N - 1 - (b * BITS + i)];
		return d;
	endfunction

	task automatic send_beat(input logic [BITS-1:0] data);
		logic took;
		in_valid = 1'b1;
		in_data  = data;
		took     = 1'b0;
		while (!took) begin
			took = in_ready;                            // stable until the next edge.
			next_cycle();
		end
		in_valid = 1'b0;
	endtask

	task automatic send_word(input logic [15:0] cw, input bit gaps);
		int gap;
		for (int b = 0; b < BEATS; b++) begin
			if (gaps) begin
				gap = $unsigned($random(seed_feed)) % 4;
				repeat (gap) next_cycle();
			end
			send_beat(beat_bits(cw, b));
		end
	endtask

	// ********************
	// processes
	// ********************

	initial begin : feeder
		wait (rst_n === 1'b1);
		next_cycle();
		for (int p = 0; p < NUM_PASS; p++) begin
			for (int v = 0; v < NUM_VEC; v++)
				send_word(stim_mem[2 * v], p == 1);
		end
	end

	initial begin : receiver
		logic [SYN_W-1:0] exp_syn;
		logic [SYN_W-1:0] held_syn;
		bit               holding;
		holding  = 1'b0;
		held_syn = '0;
		wait (rst_n === 1'b1);
		forever begin
			next_cycle();
			syn_ready = ($unsigned($random(seed_rcv)) % 3) != 0;
			if (holding && syn_valid)
				check_value(32'(syn), 32'(held_syn), "syn changed while held");
			holding  = syn_valid && !syn_ready;
			held_syn = syn;
			if (syn_valid && syn_ready) begin
				exp_syn = stim_mem[2 * (rcv_cnt % NUM_VEC) + 1];
				check_value(32'(syn), 32'(exp_syn), $sformatf("syndromes of result %0d", rcv_cnt));
				check_value(32'(syn_error), 32'(exp_syn != '0), "syn_error flag");
				check_value(32'(syn[2*M-1:M]), 32'(gf_square(syn[M-1:0])), "S2 against S1 squared");
				check_value(32'(syn[4*M-1:3*M]), 32'(gf_square(syn[2*M-1:M])),
					"S4 against S2 squared");
				rcv_cnt++;                              // results come in file order.
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("timeout: the results did not all arrive in time");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin : main
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		syn_ready = 1'b0;
		seed_feed = SEED;
		seed_rcv  = SEED;
		rcv_cnt   = 0;
		$readmemh(STIM_FILE, stim_mem);
		build_gf_tables();
		repeat (RST_CYC) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		check_value(32'(syn_valid), 32'd0, "syn_valid after reset");
		check_value(32'(in_ready), 32'd1, "in_ready after reset");
		wait (rcv_cnt == NUM_VEC * NUM_PASS);
		repeat (2 * BEATS) next_cycle();
		check_value(32'(syn_valid), 32'd0, "extra result after the last vector");
		$display("test passed");
		$finish;
	end

endmodule

// File: sim/syn_stim.txt
// codeword in hex (bit k is the coefficient of x^k), then S4 S3 S2 S1 one nibble each
// valid codewords first, then words with one bit error, then words with two
0000 0000
01D1 0000
03A2 0000
0273 0000
7440 0000
7591 0000
7FFF 0000
0001 1111
4000 EFD9
01F1 6176
7DFF CF8A
0191 A8FC
0003 2953
43AA 1511
02F7 80AF
7840 E9D9
1010 A3FC
1FFF 5534
00D3 7267

// File: compile.f
rtl/bch_pkg.sv
rtl/gf_mult.sv
rtl/syn_unit.sv
rtl/syn_expand.sv
rtl/syn_ctrl.sv
rtl/bch_syndrome.sv
sim/bch_syndrome_properties.sv
sim/bch_syndrome_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module bch_syndrome_tb -f compile.f \
	&& ./obj_dir/Vbch_syndrome_tb | tee /dev/stderr | grep -qx "test passed" \
	&& echo "simulation ok" \
	|| { echo "simulation reported failure"; exit 1; }
